//--- verilog/au_params.svh
//##################################################
// arithmetic unit sizing: data width, data stack
// depth and apb address bits
//##################################################
`ifndef AU_PARAMS_SVH
`define AU_PARAMS_SVH

`define AU_DSZ      32      // data path width
`define AU_SS_DEPTH 16      // stack entries below tos
`define AU_SP_W     5       // holds 0..16
`define AU_ADDR_W   4       // apb byte address, 4 regs

`endif

//--- verilog/au_pkg.sv
//##################################################
// arithmetic unit types: opcodes, stack actions,
// command word and status bit positions
//##################################################
package au_pkg;

    // jvm bytecode values where one exists
    typedef enum logic [7:0] {
        nop       = 8'h00,
        iconst_m1 = 8'h02,
        iconst_0  = 8'h03,
        iconst_1  = 8'h04,
        bipush    = 8'h10,
        pop       = 8'h57,
        dup       = 8'h59,
        swap      = 8'h5f,
        iadd      = 8'h60,
        isub      = 8'h64,
        imul      = 8'h68,
        idiv      = 8'h6c,
        irem      = 8'h70,
        ineg      = 8'h74,
        ishl      = 8'h78,
        ishr      = 8'h7a,
        iushr     = 8'h7c,
        iand      = 8'h7e,
        ior       = 8'h80,
        ixor      = 8'h82
    } opcode_t;

    typedef enum logic [1:0] {
        s_nop,
        s_push,
        s_pop,
        s_write                 // overwrite nos, swap only
    } stack_op_t;

    // cmd register word, seen as a whole or as op + imm
    typedef union packed {
        struct packed {
            opcode_t     op;
            logic [23:0] imm;   // sign extended on bipush
        } ins;
        logic [31:0] raw;
    } au_cmd_u;

    localparam int ST_BUSY     = 0;
    localparam int ST_OVF      = 1;
    localparam int ST_UNF      = 2;
    localparam int ST_DEPTH_LO = 8;
    localparam int ST_DEPTH_HI = 12;

endpackage

//--- verilog/au_if.sv
//##################################################
// arithmetic unit internal buses: command path,
// alu operands and data stack control
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

interface au_cmd_if;
    import au_pkg::*;
    logic                cmd_valid;     // one cycle per accepted write
    au_cmd_u             cmd;           // held until next accept
    logic [1:0]          err_clr;       // {unf, ovf} clear mask
    logic                busy;
    logic [`AU_DSZ-1:0]  tos;
    logic [`AU_DSZ-1:0]  nos;
    logic                ovf;
    logic                unf;
    logic [`AU_SP_W-1:0] depth;         // entries below tos

    modport slave    (output cmd_valid, cmd, err_clr,
                      input  busy, tos, nos, ovf, unf, depth);
    modport dispatch (input  cmd_valid, cmd, err_clr,
                      output busy, tos, nos, ovf, unf, depth);
endinterface

interface au_alu_if;
    import au_pkg::*;
    opcode_t            code;
    logic [`AU_DSZ-1:0] tos;
    logic [`AU_DSZ-1:0] nos;
    logic               div_start;      // pulse
    logic [`AU_DSZ-1:0] result;
    logic               div_busy;
    logic               div_done;       // pulse, result valid

    modport dispatch (output code, tos, nos, div_start,
                      input  result, div_busy, div_done);
    modport alu      (input  code, tos, nos, div_start,
                      output result, div_busy, div_done);
endinterface

interface au_stack_if;
    import au_pkg::*;
    stack_op_t           op;
    logic [`AU_DSZ-1:0]  wdata;
    logic [`AU_DSZ-1:0]  nos;           // 0 when empty
    logic [`AU_SP_W-1:0] depth;
    logic                full;
    logic                empty;

    modport dispatch (output op, wdata, input nos, depth, full, empty);
    modport stack    (input op, wdata, output nos, depth, full, empty);
endinterface

//--- verilog/au_apb_slave.sv
//##################################################
// apb front end: cmd issue with busy back-pressure,
// tos/nos/status readback, sticky error clear
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_apb_slave (
    input  logic                  ctl,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [`AU_ADDR_W-1:0] paddr_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    au_cmd_if.slave               cif
);
    import au_pkg::*;

    localparam logic [`AU_ADDR_W-1:0] A_CMD = 'h0;
    localparam logic [`AU_ADDR_W-1:0] A_TOS = 'h4;
    localparam logic [`AU_ADDR_W-1:0] A_NOS = 'h8;
    localparam logic [`AU_ADDR_W-1:0] A_STS = 'hc;

    logic               access;         // apb access phase
    logic               sel_cmd, sel_tos, sel_nos, sel_sts;
    logic               hit;
    logic               wr_cmd, wr_sts;
    logic [`AU_DSZ-1:0] status;

    assign access  = psel_i & penable_i;
    assign sel_cmd = paddr_i == A_CMD;
    assign sel_tos = paddr_i == A_TOS;
    assign sel_nos = paddr_i == A_NOS;
    assign sel_sts = paddr_i == A_STS;
    assign hit     = sel_cmd | sel_tos | sel_nos | sel_sts;

    // only a cmd write waits, and only while the unit is busy
    assign pready_o  = access & ~(pwrite_i & sel_cmd & cif.busy);
    assign pslverr_o = access & ~hit;   // unmapped, no side effect

    assign wr_cmd = pready_o & hit & pwrite_i & sel_cmd;
    assign wr_sts = pready_o & hit & pwrite_i & sel_sts;

    always_comb begin
        status = '0;
        status[ST_BUSY] = cif.busy;
        status[ST_OVF]  = cif.ovf;
        status[ST_UNF]  = cif.unf;
        status[ST_DEPTH_HI:ST_DEPTH_LO] = cif.depth;
    end

    always_comb begin
        case (paddr_i)
            A_TOS:   prdata_o = cif.tos;
            A_NOS:   prdata_o = cif.nos;
            A_STS:   prdata_o = status;
            default: prdata_o = '0;     // cmd is write only
        endcase
    end

    always_ff @(posedge ctl) begin
        if (!rst_n_i) begin
            cif.cmd_valid <= 1'b0;
            cif.err_clr   <= 2'b00;
        end else begin
            cif.cmd_valid <= wr_cmd;    // issue one cycle after accept
            cif.err_clr   <= wr_sts ? pwdata_i[ST_UNF:ST_OVF] : 2'b00;
        end
    end

    // command word, stays put while the op runs
    always_ff @(posedge ctl) begin
        if (wr_cmd) begin
            cif.cmd.raw <= pwdata_i;
        end
    end

endmodule

//--- verilog/au_alu.sv
//##################################################
// alu datapath: add/sub/mul/neg, logic, shifts and
// a 32-cycle restoring signed divider
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_alu (
    input  logic  ctl,
    input  logic  rst_n_i,
    au_alu_if.alu aif
);
    import au_pkg::*;

    localparam int MSB = `AU_DSZ - 1;
    localparam int CW  = $clog2(`AU_DSZ);

    logic [MSB:0]  a, b;                // nos, tos
    logic [CW-1:0] sh;
    logic [MSB:0]  quo, rem, dsr;
    logic [MSB:0]  q_out, r_out;
    logic [MSB+1:0] rem_sh, diff;
    logic [CW-1:0] cnt;
    logic          running;
    logic          neg_q, neg_r;

    assign a  = aif.nos;
    assign b  = aif.tos;
    assign sh = b[CW-1:0];              // low 5 bits of tos

    always_comb begin
        case (aif.code)
            iadd:    aif.result = a + b;
            isub:    aif.result = a - b;
            imul:    aif.result = a * b;        // low word only
            ineg:    aif.result = -b;
            iand:    aif.result = a & b;
            ior:     aif.result = a | b;
            ixor:    aif.result = a ^ b;
            ishl:    aif.result = a << sh;
            ishr:    aif.result = $signed(a) >>> sh;
            iushr:   aif.result = a >> sh;
            idiv:    aif.result = q_out;
            irem:    aif.result = r_out;
            default: aif.result = b;
        endcase
    end

    // one quotient bit per cycle on magnitudes
    assign rem_sh = {rem, quo[MSB]};
    assign diff   = rem_sh - {1'b0, dsr};

    // sign fixup, truncation toward zero
    assign q_out = neg_q ? -quo : quo;
    assign r_out = neg_r ? -rem : rem;

    assign aif.div_busy = running;

    always_ff @(posedge ctl) begin
        if (!rst_n_i) begin
            running      <= 1'b0;
            cnt          <= '0;
            aif.div_done <= 1'b0;
        end else begin
            aif.div_done <= running && cnt == CW'(MSB);   // last step
            if (aif.div_start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(MSB)) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge ctl) begin
        if (aif.div_start) begin
            quo   <= a[MSB] ? -a : a;   // dividend shifts out as quotient fills
            dsr   <= b[MSB] ? -b : b;
            rem   <= '0;
            neg_r <= a[MSB];            // remainder follows dividend
            // zero divisor leaves quotient all ones, unsigned
            neg_q <= (a[MSB] ^ b[MSB]) & (|b);
        end else if (running) begin
            quo <= {quo[MSB-1:0], ~diff[MSB+1]};
            rem <= diff[MSB+1] ? rem_sh[MSB:0] : diff[MSB:0];   // restore on borrow
        end
    end

endmodule

//--- verilog/au_data_stack.sv
//##################################################
// data stack below tos: register array, pointer,
// full/empty flags
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_data_stack (
    input  logic      ctl,
    input  logic      rst_n_i,
    au_stack_if.stack sif
);
    import au_pkg::*;

    localparam int IW = $clog2(`AU_SS_DEPTH);

    logic [`AU_DSZ-1:0]  mem [`AU_SS_DEPTH];
    logic [`AU_SP_W-1:0] sp;            // next free slot = depth
    logic [`AU_SP_W-1:0] top;           // nos slot

    assign top       = sp - 1'b1;
    assign sif.depth = sp;
    assign sif.full  = sp == `AU_SP_W'(`AU_SS_DEPTH);
    assign sif.empty = sp == '0;
    assign sif.nos   = sif.empty ? '0 : mem[top[IW-1:0]];

    always_ff @(posedge ctl) begin
        if (!rst_n_i) begin
            sp <= '0;
        end else begin
            case (sif.op)
                s_push:  if (!sif.full) sp <= sp + 1'b1;
                s_pop:   if (!sif.empty) sp <= top;
                default: sp <= sp;      // nop, write keep depth
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (sif.op == s_push && !sif.full) begin
            mem[sp[IW-1:0]] <= sif.wdata;       // old tos goes under
        end else if (sif.op == s_write && !sif.empty) begin
            mem[top[IW-1:0]] <= sif.wdata;      // swap
        end
    end

endmodule

//--- verilog/au_dispatch.sv
//##################################################
// opcode sequencer: owns tos, merges alu and stack
// results, runs divides, keeps sticky ovf/unf
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_dispatch (
    input  logic         ctl,
    input  logic         rst_n_i,
    au_cmd_if.dispatch   cif,
    au_alu_if.dispatch   aif,
    au_stack_if.dispatch sif
);
    import au_pkg::*;

    localparam logic [1:0] P_IDLE  = 2'd0;
    localparam logic [1:0] P_START = 2'd1;     // div_start cycle
    localparam logic [1:0] P_WAIT  = 2'd2;     // until div_done

    opcode_t             op;
    logic [1:0]          phase;
    logic [`AU_DSZ-1:0]  tos, tos_n;
    logic [`AU_DSZ-1:0]  imm_x;
    logic                tos_v, tv_n;   // tos holds a live value
    logic                ovf, unf;
    logic [`AU_SP_W-1:0] ldepth;        // logical depth incl. tos
    logic [1:0]          need;          // operands required
    logic                push, div_go;
    stack_op_t           st_op;
    logic                err_u, err_o;
    logic                exec;
    logic                tos_we;

    assign op     = cif.cmd.ins.op;
    assign imm_x  = {{(`AU_DSZ-24){cif.cmd.ins.imm[23]}}, cif.cmd.ins.imm};
    assign ldepth = sif.depth + `AU_SP_W'(tos_v);

    always_comb begin
        tos_n  = tos;
        tv_n   = tos_v;
        st_op  = s_nop;
        need   = 2'd0;
        push   = 1'b0;
        div_go = 1'b0;
        case (op)
            iconst_m1: begin push = 1'b1; tos_n = '1;             end
            iconst_0:  begin push = 1'b1; tos_n = '0;             end
            iconst_1:  begin push = 1'b1; tos_n = `AU_DSZ'(1);   end
            bipush:    begin push = 1'b1; tos_n = imm_x;          end
            dup: begin
                need = 2'd1;
                push = 1'b1;            // tos_n stays tos
            end
            pop: begin
                need  = 2'd1;
                tos_n = sif.nos;        // 0 once the stack runs dry
                tv_n  = ~sif.empty;
                st_op = sif.empty ? s_nop : s_pop;
            end
            swap: begin
                need  = 2'd2;
                tos_n = sif.nos;
                st_op = s_write;        // old tos into nos slot
            end
            iadd, isub, imul, iand, ior, ixor, ishl, ishr, iushr: begin
                need  = 2'd2;
                tos_n = aif.result;
                st_op = s_pop;
            end
            ineg: begin
                need  = 2'd1;
                tos_n = aif.result;
            end
            idiv, irem: begin
                need   = 2'd2;
                div_go = 1'b1;          // result lands after div_done
            end
            default: need = 2'd0;       // nop and unknown codes
        endcase
        if (push) begin
            tv_n = 1'b1;
            if (tos_v) st_op = s_push;  // empty machine only fills tos
        end
        if (phase == P_WAIT) begin      // divide write-back
            tos_n  = aif.result;
            tv_n   = 1'b1;
            st_op  = s_pop;
            div_go = 1'b0;
        end
    end

    assign err_u  = cif.cmd_valid & (ldepth < `AU_SP_W'(need));
    assign err_o  = cif.cmd_valid & push & tos_v & sif.full;   // logical depth 17
    assign exec   = (cif.cmd_valid & ~err_u & ~err_o) | (phase == P_WAIT & aif.div_done);
    assign tos_we = exec & ~div_go;

    assign sif.op    = exec ? st_op : s_nop;
    assign sif.wdata = tos;

    always_ff @(posedge ctl) begin
        if (!rst_n_i) begin
            phase <= P_IDLE;
            tos   <= '0;
            tos_v <= 1'b0;
            ovf   <= 1'b0;
            unf   <= 1'b0;
        end else begin
            if (tos_we) begin
                tos   <= tos_n;
                tos_v <= tv_n;
            end
            case (phase)
                P_IDLE:  if (exec && div_go) phase <= P_START;
                P_START: phase <= P_WAIT;
                default: if (aif.div_done) phase <= P_IDLE;
            endcase
            if (cif.err_clr[0]) ovf <= 1'b0;
            if (cif.err_clr[1]) unf <= 1'b0;
            if (err_o) ovf <= 1'b1;     // set wins
            if (err_u) unf <= 1'b1;
        end
    end

    // busy from issue through the div_done cycle
    assign cif.busy  = cif.cmd_valid | (phase != P_IDLE) | aif.div_busy;
    assign cif.tos   = tos;
    assign cif.nos   = sif.nos;
    assign cif.ovf   = ovf;
    assign cif.unf   = unf;
    assign cif.depth = sif.depth;

    assign aif.code      = op;
    assign aif.tos       = tos;
    assign aif.nos       = sif.nos;
    assign aif.div_start = phase == P_START;

endmodule

//--- verilog/au_top.sv
//##################################################
// stack machine arithmetic unit, apb slave top
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_top (
    input  logic                  ctl,
    input  logic                  rst_n_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [`AU_ADDR_W-1:0] paddr_i,
    input  logic [31:0]           pwdata_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o
);

    au_cmd_if   cmd_if ();              // slave <-> dispatch
    au_alu_if   alu_if ();              // dispatch <-> alu
    au_stack_if stk_if ();              // dispatch <-> stack

    au_apb_slave u_apb (
        .ctl       (ctl),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cif       (cmd_if.slave)
    );

    au_dispatch u_disp (
        .ctl     (ctl),
        .rst_n_i (rst_n_i),
        .cif     (cmd_if.dispatch),
        .aif     (alu_if.dispatch),
        .sif     (stk_if.dispatch)
    );

    au_alu u_alu (
        .ctl     (ctl),
        .rst_n_i (rst_n_i),
        .aif     (alu_if.alu)
    );

    au_data_stack u_stack (
        .ctl     (ctl),
        .rst_n_i (rst_n_i),
        .sif     (stk_if.stack)
    );

endmodule

//--- test/au_tb_table.svh
//##################################################
// command table: one row per opcode with expected
// tos, nos, depth, error bits and pslverr
//##################################################
`ifndef AU_TB_TABLE_SVH
`define AU_TB_TABLE_SVH

// columns: opcode, imm, then expected tos, nos, depth, ovf, unf, pslverr
task automatic build_table();
    add_row(iconst_1,  24'h000000, 32'h0000_0001, 32'h0000_0000, 5'd0, 0, 0, 0);
    add_row(iconst_m1, 24'h000000, 32'hffff_ffff, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h800005, 32'hff80_0005, 32'hffff_ffff, 5'd2, 0, 0, 0);
    add_row(bipush,    24'h00007f, 32'h0000_007f, 32'hff80_0005, 5'd3, 0, 0, 0);
    add_row(dup,       24'h000000, 32'h0000_007f, 32'h0000_007f, 5'd4, 0, 0, 0);
    add_row(pop,       24'h000000, 32'h0000_007f, 32'hff80_0005, 5'd3, 0, 0, 0);
    add_row(swap,      24'h000000, 32'hff80_0005, 32'h0000_007f, 5'd3, 0, 0, 0);
    // written to an unmapped address, nothing may move
    add_row(bipush,    24'h000055, 32'hff80_0005, 32'h0000_007f, 5'd3, 0, 0, 1);
    add_row(iadd,      24'h000000, 32'hff80_0084, 32'hffff_ffff, 5'd2, 0, 0, 0);
    add_row(isub,      24'h000000, 32'h007f_ff7b, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000003, 32'h0000_0003, 32'h007f_ff7b, 5'd2, 0, 0, 0);
    add_row(imul,      24'h000000, 32'h017f_fe71, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(ineg,      24'h000000, 32'hfe80_018f, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h00f0f0, 32'h0000_f0f0, 32'hfe80_018f, 5'd2, 0, 0, 0);
    add_row(iand,      24'h000000, 32'h0000_0080, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000f0f, 32'h0000_0f0f, 32'h0000_0080, 5'd2, 0, 0, 0);
    add_row(ior,       24'h000000, 32'h0000_0f8f, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'hffffff, 32'hffff_ffff, 32'h0000_0f8f, 5'd2, 0, 0, 0);
    add_row(ixor,      24'h000000, 32'hffff_f070, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000024, 32'h0000_0024, 32'hffff_f070, 5'd2, 0, 0, 0);  // count 4
    add_row(ishr,      24'h000000, 32'hffff_ff07, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000008, 32'h0000_0008, 32'hffff_ff07, 5'd2, 0, 0, 0);
    add_row(iushr,     24'h000000, 32'h00ff_ffff, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000004, 32'h0000_0004, 32'h00ff_ffff, 5'd2, 0, 0, 0);
    add_row(ishl,      24'h000000, 32'h0fff_fff0, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'hfffff5, 32'hffff_fff5, 32'h0fff_fff0, 5'd2, 0, 0, 0);  // -11
    add_row(idiv,      24'h000000, 32'hfe8b_a2eb, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000005, 32'h0000_0005, 32'hfe8b_a2eb, 5'd2, 0, 0, 0);
    add_row(irem,      24'h000000, 32'hffff_ffff, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(bipush,    24'h000123, 32'h0000_0123, 32'hffff_ffff, 5'd2, 0, 0, 0);
    add_row(iconst_0,  24'h000000, 32'h0000_0000, 32'h0000_0123, 5'd3, 0, 0, 0);
    add_row(idiv,      24'h000000, 32'hffff_ffff, 32'hffff_ffff, 5'd2, 0, 0, 0);  // by zero
    add_row(pop,       24'h000000, 32'hffff_ffff, 32'h0000_0001, 5'd1, 0, 0, 0);
    add_row(pop,       24'h000000, 32'h0000_0001, 32'h0000_0000, 5'd0, 0, 0, 0);
    add_row(iadd,      24'h000000, 32'h0000_0001, 32'h0000_0000, 5'd0, 0, 1, 0);  // one deep
    add_row(pop,       24'h000000, 32'h0000_0000, 32'h0000_0000, 5'd0, 0, 0, 0);
    add_row(ineg,      24'h000000, 32'h0000_0000, 32'h0000_0000, 5'd0, 0, 1, 0);  // empty
    add_row(pop,       24'h000000, 32'h0000_0000, 32'h0000_0000, 5'd0, 0, 1, 0);
endtask

`endif

//--- test/au_tb.sv
//##################################################
// arithmetic unit testbench: apb driver, command
// table, overflow, stalled writes, random divides
//##################################################
`timescale 1ns/1ps
`include "au_params.svh"

module au_tb;
    import au_pkg::*;

    localparam int PERIOD = 40;
    localparam int N_RAND = 8;              // two divides each
    localparam logic [`AU_ADDR_W-1:0] A_CMD = 'h0;
    localparam logic [`AU_ADDR_W-1:0] A_TOS = 'h4;
    localparam logic [`AU_ADDR_W-1:0] A_NOS = 'h8;
    localparam logic [`AU_ADDR_W-1:0] A_STS = 'hc;
    localparam logic [`AU_ADDR_W-1:0] A_BAD = 'h2;     // unmapped

    typedef struct packed {
        opcode_t     op;
        logic [23:0] imm;
        logic [31:0] tos;
        logic [31:0] nos;
        logic [4:0]  depth;
        logic        ovf;
        logic        unf;
        logic        slverr;                // issue to A_BAD instead
    } row_t;

    logic                  ctl;
    logic                  rst_n_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [`AU_ADDR_W-1:0] paddr_i;
    logic [31:0]           pwdata_i;
    logic [31:0]           prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;

    row_t   rows[$];
    integer seed = 32'h2b3d_ff7a;
    int     cycles = 0;
    int     cycle_limit = 0;

    au_top au_top_i (.*);

    initial begin
        ctl = 1'b0;
        forever #(PERIOD / 2) ctl = ~ctl;
    end

    // run length guard, set once the table is built
    always @(posedge ctl) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout: the unit did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, act, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one apb transfer, starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input logic [`AU_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
        logic done;
        done  = 1'b0;
        waits = 0;
        rdata = '0;
        err   = 1'b0;
        @(negedge ctl);                     // setup phase
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge ctl);
        penable_i = 1'b1;
        while (!done) begin
            #(PERIOD / 4);                  // well clear of both edges
            if (pready_o) begin
                rdata = prdata_o;
                err   = pslverr_o;
                done  = 1'b1;
            end else begin
                waits++;                    // back-pressure cycle
            end
            @(negedge ctl);
        end
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_read(input logic [`AU_ADDR_W-1:0] addr, output logic [31:0] data);
        logic err;
        int   waits;
        apb_xfer(1'b0, addr, '0, data, err, waits);
        check("pslverr_o on read", 32'(err), 32'd0);
    endtask

    task automatic apb_write(input logic [`AU_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic err, output int waits);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, err, waits);
    endtask

    // issue without waiting for the unit
    task automatic issue_cmd(input opcode_t op, input logic [23:0] imm,
                             input logic [`AU_ADDR_W-1:0] addr, input logic exp_err,
                             output int waits);
        au_cmd_u cmd;
        logic    err;
        cmd.ins.op  = op;
        cmd.ins.imm = imm;
        apb_write(addr, cmd.raw, err, waits);
        check("pslverr_o on cmd", 32'(err), 32'(exp_err));
    endtask

    task automatic wait_idle();
        logic [31:0] sts;
        sts = 32'h1;
        while (sts[0]) begin                // busy bit
            apb_read(A_STS, sts);
        end
    endtask

    task automatic run_cmd(input opcode_t op, input logic [23:0] imm);
        int waits;
        issue_cmd(op, imm, A_CMD, 1'b0, waits);
        wait_idle();
    endtask

    task automatic clear_errors();
        logic err;
        int   waits;
        apb_write(A_STS, 32'h0000_0006, err, waits);    // ovf and unf
        check("pslverr_o on status", 32'(err), 32'd0);
    endtask

    // status layout: busy 0, ovf 1, unf 2, depth 12:8
    function automatic logic [31:0] sts_word(input logic [4:0] depth, input logic ovf,
                                             input logic unf);
        logic [31:0] w;
        w       = '0;
        w[12:8] = depth;
        w[2]    = unf;
        w[1]    = ovf;
        return w;
    endfunction

    task automatic check_state(input logic [31:0] tos, input logic [31:0] nos,
                               input logic [4:0] depth, input logic ovf, input logic unf);
        logic [31:0] rd;
        apb_read(A_TOS, rd);
        check("tos", rd, tos);
        apb_read(A_NOS, rd);
        check("nos", rd, nos);
        apb_read(A_STS, rd);
        check("status", rd, sts_word(depth, ovf, unf));
    endtask

    // signed, toward zero; zero divisor gives all ones and the dividend
    function automatic logic [31:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic want_rem);
        if (b == '0) begin
            return want_rem ? a : 32'hffff_ffff;
        end
        return want_rem ? 32'($signed(a) % $signed(b)) : 32'($signed(a) / $signed(b));
    endfunction

    task automatic add_row(input opcode_t op, input logic [23:0] imm,
                           input logic [31:0] tos, input logic [31:0] nos,
                           input logic [4:0] depth, input logic ovf,
                           input logic unf, input logic slverr);
        row_t r;
        r = '{op, imm, tos, nos, depth, ovf, unf, slverr};
        rows.push_back(r);
    endtask

    task automatic do_reset();
        logic [31:0] rd;
        rst_n_i = 1'b0;
        repeat (5) @(negedge ctl);
        rst_n_i = 1'b1;
        apb_read(A_STS, rd);
        check("status after reset", rd, 32'h0);
        apb_read(A_TOS, rd);
        check("tos after reset", rd, 32'h0);
    endtask

    `include "au_tb_table.svh"

    initial begin
        logic [23:0] a_imm;
        logic [23:0] b_imm;
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] q;
        logic [31:0] r;
        int          waits;
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        build_table();
        cycle_limit = 60 * rows.size() + 120 * 2 * N_RAND;
        do_reset();

        foreach (rows[i]) begin
            issue_cmd(rows[i].op, rows[i].imm, rows[i].slverr ? A_BAD : A_CMD,
                      rows[i].slverr, waits);
            wait_idle();
            check_state(rows[i].tos, rows[i].nos, rows[i].depth, rows[i].ovf, rows[i].unf);
            if (rows[i].ovf || rows[i].unf) begin
                clear_errors();
                check_state(rows[i].tos, rows[i].nos, rows[i].depth, 1'b0, 1'b0);
            end
        end

        // tos plus 16 entries is full, the next push must bounce
        for (int k = 1; k <= 17; k++) begin
            run_cmd(bipush, 24'(k));
        end
        check_state(32'd17, 32'd16, 5'd16, 1'b0, 1'b0);
        run_cmd(bipush, 24'h000099);
        check_state(32'd17, 32'd16, 5'd16, 1'b1, 1'b0);
        clear_errors();
        check_state(32'd17, 32'd16, 5'd16, 1'b0, 1'b0);

        do_reset();                         // empty machine for the divides
        for (int i = 0; i < N_RAND; i++) begin
            rnd   = $random(seed);
            a_imm = rnd[23:0];
            rnd   = $random(seed);
            b_imm = $signed(rnd[23:0]) >>> rnd[27:24];     // mix in small divisors
            if (i % 4 == 3) begin
                b_imm = '0;
            end
            a = {{8{a_imm[23]}}, a_imm};
            b = {{8{b_imm[23]}}, b_imm};
            q = div_model(a, b, 1'b0);
            r = div_model(a, b, 1'b1);
            run_cmd(bipush, a_imm);
            run_cmd(bipush, b_imm);
            issue_cmd(idiv, '0, A_CMD, 1'b0, waits);
            issue_cmd(bipush, a_imm, A_CMD, 1'b0, waits);  // lands mid divide
            check("cmd write stalled", 32'(waits > 0), 32'd1);
            run_cmd(bipush, b_imm);
            run_cmd(irem, '0);
            check_state(r, q, 5'd1, 1'b0, 1'b0);       // quotient sits below
            run_cmd(pop, '0);
            check_state(q, 32'd0, 5'd0, 1'b0, 1'b0);
            run_cmd(pop, '0);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+verilog
+incdir+test
verilog/au_pkg.sv
verilog/au_if.sv
verilog/au_apb_slave.sv
verilog/au_alu.sv
verilog/au_data_stack.sv
verilog/au_dispatch.sv
verilog/au_top.sv
test/au_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the arithmetic unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module au_tb \
    -Mdir obj_dir -o au_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/au_sim > "$SIM_LOG" 2>&1
sim_status=$?

if grep -q "SIMULATION FAILED" "$SIM_LOG"; then
    echo "test failed, see $SIM_LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status, see $SIM_LOG"
    exit 1
fi
echo "test passed"
exit 0
